// ==== compile.f ====
+incdir+rtl
rtl/gat_pkg.sv
rtl/stream_if.sv
rtl/wh_stage.sv
rtl/act_stage.sv
rtl/aggr_stage.sv
rtl/debug_monitor.sv
rtl/gat_top.sv
sim/tb_gat_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gat_top
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) rtl/gat_macros.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_gat_top.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module tb_gat_top import gat_pkg::*; ();

  localparam int NODES      = 8;
  // four rounds of eight nodes with at most four edges each.
  localparam int PLAN_EDGES = 4 * NODES * 4;
  localparam int SETUP_CYC  = 200;
  localparam int ACT_MAX    = (1 << (`GAT_ACT_W - 1)) - 1;
  localparam int ACT_MIN    = -(1 << (`GAT_ACT_W - 1));
  localparam logic [`GAT_NODE_W-1:0] WATCH = 8'd3;

  logic                          clk;
  logic                          rst_n;
  logic                          in_valid_i;
  logic                          in_ready_o;
  logic [`GAT_NODE_W-1:0]        in_node_i;
  logic                          in_last_i;
  feat_vec_t                     in_feat_i;
  logic                          out_valid_o;
  logic                          out_ready_i;
  logic [`GAT_NODE_W-1:0]        out_node_o;
  logic [`GAT_VALUE_W-1:0]       out_sum_o;
  logic                          wgt_we_i;
  logic [1:0]                    wgt_idx_i;
  logic signed [`GAT_FEAT_W-1:0] wgt_data_i;
  logic [`GAT_NODE_W-1:0]        watch_node_i;
  logic                          dbg_clear_i;
  logic [7:0]                    dbg_flags_o;
  logic [31:0]                   dbg_edges_o;
  logic [`GAT_VALUE_W-1:0]       dbg_capture_o;

  logic [31:0]                   lfsr_q;
  logic signed [`GAT_FEAT_W-1:0] wgt_m [`GAT_LANES];
  logic [`GAT_NODE_W-1:0]        exp_node_q [$];
  logic [31:0]                   exp_sum_q [$];
  int                            last_cyc_q [$];
  int                            cyc;
  int                            in_count;
  int                            errors;
  int                            checks;
  logic                          bp_on;
  logic                          lat_check;
  logic                          sat_mode;
  logic [31:0]                   cap_exp;
  logic                          prev_hold;
  logic [`GAT_NODE_W-1:0]        hold_node;
  logic [31:0]                   hold_sum;

  gat_top DUT (.*);

  always #2 clk = ~clk;

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // dot product, leaky relu and clamp for one edge.
  function automatic logic [31:0] act_model(input feat_vec_t f);
    int dot;
    dot = 0;
    for (int i = 0; i < `GAT_LANES; i++) begin
      dot += int'(f[i]) * int'(wgt_m[i]);
    end
    if (dot < 0) begin
      dot = dot >>> `GAT_LEAK_SHIFT;
    end
    if (dot > ACT_MAX) begin
      dot = ACT_MAX;
    end else if (dot < ACT_MIN) begin
      dot = ACT_MIN;
    end
    return dot;
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED @%0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // wait one clock and pick out_ready_i for the next cycle.
  task automatic tick(output logic rdy);
    logic [31:0] r;
    @(posedge clk);
    rdy = in_ready_o;
    #1;
    r = rand_bits(1);
    out_ready_i = bp_on ? r[0] : 1'b1;
  endtask

  task automatic load_weights();
    logic        rdy;
    logic [31:0] r;
    for (int i = 0; i < `GAT_LANES; i++) begin
      r = rand_bits(`GAT_FEAT_W);
      wgt_m[i]   = sat_mode ? 8'sd127 : r[7:0];
      wgt_we_i   = 1'b1;
      wgt_idx_i  = 2'(i);
      wgt_data_i = wgt_m[i];
      tick(rdy);
    end
    wgt_we_i = 1'b0;
  endtask

  task automatic send_node(input logic [`GAT_NODE_W-1:0] node);
    int          n_edges;
    logic [31:0] sum;
    logic [31:0] act;
    logic [31:0] r;
    feat_vec_t   f;
    logic        rdy;
    n_edges = int'(rand_bits(2)) + 1;
    sum = '0;
    for (int e = 0; e < n_edges; e++) begin
      r = rand_bits(1);
      if (r[0]) begin
        in_valid_i = 1'b0;
        tick(rdy);
      end
      f = sat_mode ? {`GAT_LANES{8'sd127}} : rand_bits(32);
      act = act_model(f);
      sum = sum + act;
      in_valid_i = 1'b1;
      in_node_i  = node;
      in_last_i  = (e == n_edges - 1);
      in_feat_i  = f;
      rdy = 1'b0;
      while (!rdy) begin
        tick(rdy);
      end
      in_valid_i = 1'b0;
      if (node == WATCH) begin
        cap_exp = act;
      end
    end
    exp_node_q.push_back(node);
    exp_sum_q.push_back(sum);
  endtask

  task automatic run_phase(input int rounds);
    logic rdy;
    load_weights();
    for (int r = 0; r < rounds; r++) begin
      for (int n = 0; n < NODES; n++) begin
        send_node(8'(n));
      end
    end
    while (exp_node_q.size() != 0) begin
      tick(rdy);
    end
    repeat (4) tick(rdy);
    check_val("dbg_edges_o", dbg_edges_o, in_count);
    check_val("dbg_capture_o", dbg_capture_o, cap_exp);
    check_val("dbg_flags_o", {24'd0, dbg_flags_o}, 32'hff);
  endtask

  // output transfers, hold stability and latency.
  always @(posedge clk) begin
    int lc;
    if (rst_n) begin
      cyc++;
      if (in_valid_i && in_ready_o) begin
        in_count++;
        if (in_last_i) begin
          last_cyc_q.push_back(cyc);
        end
      end
      if (prev_hold && (!out_valid_o || out_node_o !== hold_node || out_sum_o !== hold_sum)) begin
        errors++;
        $display("FAILED @%0t: output changed while stalled", $time);
      end
      if (out_valid_o && out_ready_i) begin
        if (exp_node_q.size() == 0) begin
          errors++;
          $display("output for node %0d arrived with no node pending", out_node_o);
        end else begin
          check_val("out_node_o", {24'd0, out_node_o}, {24'd0, exp_node_q.pop_front()});
          check_val("out_sum_o", out_sum_o, exp_sum_q.pop_front());
          lc = last_cyc_q.pop_front();
          if (lat_check && cyc != lc + 3) begin
            errors++;
            $display("FAILED @%0t: output latency %0d cycles, expected 3", $time, cyc - lc);
          end
        end
      end
      prev_hold = out_valid_o && !out_ready_i;
      hold_node = out_node_o;
      hold_sum  = out_sum_o;
    end
  end

  initial begin
    logic [7:0] idle_exp;
    clk = 1'b0;
    rst_n = 1'b0;
    in_valid_i = 1'b0;
    in_node_i = '0;
    in_last_i = 1'b0;
    in_feat_i = '0;
    out_ready_i = 1'b1;
    wgt_we_i = 1'b0;
    wgt_idx_i = '0;
    wgt_data_i = '0;
    watch_node_i = WATCH;
    dbg_clear_i = 1'b0;
    lfsr_q = 32'h5389;
    cyc = 0;
    in_count = 0;
    errors = 0;
    checks = 0;
    bp_on = 1'b0;
    lat_check = 1'b0;
    sat_mode = 1'b0;
    cap_exp = '0;
    prev_hold = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_val("dbg_flags_o after reset", {24'd0, dbg_flags_o}, 32'd0);
    check_val("dbg_edges_o after reset", dbg_edges_o, 32'd0);
    check_val("in_ready_o after reset", {31'd0, in_ready_o}, 32'd1);

    // random weights and traffic under back-pressure.
    bp_on = 1'b1;
    run_phase(2);

    // the output stays stalled, so an idle cycle shows ready on the other links only.
    idle_exp = '0;
    idle_exp[2 * int'(LINK_IN)]  = 1'b1;
    idle_exp[2 * int'(LINK_WH)]  = 1'b1;
    idle_exp[2 * int'(LINK_ACT)] = 1'b1;
    bp_on = 1'b0;
    out_ready_i = 1'b0;
    dbg_clear_i = 1'b1;
    @(posedge clk);
    #1;
    dbg_clear_i = 1'b0;
    check_val("dbg_flags_o after clear", {24'd0, dbg_flags_o}, 32'd0);
    check_val("dbg_edges_o after clear", dbg_edges_o, 32'd0);
    check_val("dbg_capture_o after clear", dbg_capture_o, 32'd0);
    @(posedge clk);
    #1;
    check_val("dbg_flags_o when idle", {24'd0, dbg_flags_o}, {24'd0, idle_exp});
    in_count = 0;
    cap_exp = '0;

    // free-flowing output for the latency check.
    out_ready_i = 1'b1;
    lat_check = 1'b1;
    run_phase(1);
    lat_check = 1'b0;

    // 127 by 127 on every lane overflows the activation range.
    bp_on = 1'b1;
    sat_mode = 1'b1;
    run_phase(1);

    $display("checks=%0d errors=%0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #(4 * (40 * PLAN_EDGES + SETUP_CYC));
    $display("timeout: the run did not finish in time, outputs are missing or stuck");
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== rtl/gat_top.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module gat_top import gat_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic [`GAT_NODE_W-1:0]        in_node_i,
  input  logic                          in_last_i,
  input  feat_vec_t                     in_feat_i,

  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic [`GAT_NODE_W-1:0]        out_node_o,
  output logic [`GAT_VALUE_W-1:0]       out_sum_o,

  input  logic                          wgt_we_i,
  input  logic [1:0]                    wgt_idx_i,
  input  logic signed [`GAT_FEAT_W-1:0] wgt_data_i,

  input  logic [`GAT_NODE_W-1:0]        watch_node_i,
  input  logic                          dbg_clear_i,
  output logic [7:0]                    dbg_flags_o,
  output logic [31:0]                   dbg_edges_o,
  output logic [`GAT_VALUE_W-1:0]       dbg_capture_o
);

  stream_if in_link  ();
  stream_if wh_link  ();
  stream_if act_link ();
  stream_if out_link ();

  // input ports onto the first link.
  assign in_link.valid = in_valid_i;
  assign in_link.node  = in_node_i;
  assign in_link.last  = in_last_i;
  assign in_link.value = in_feat_i;
  assign in_ready_o    = in_link.ready;

  // last link onto the output ports.
  assign out_valid_o    = out_link.valid;
  assign out_node_o     = out_link.node;
  assign out_sum_o      = out_link.value;
  assign out_link.ready = out_ready_i;

  wh_stage u_wh (
    .clk        (clk),
    .rst_n      (rst_n),
    .wgt_we_i   (wgt_we_i),
    .wgt_idx_i  (wgt_idx_i),
    .wgt_data_i (wgt_data_i),
    .in_s       (in_link),
    .out_s      (wh_link)
  );

  act_stage u_act (
    .clk   (clk),
    .rst_n (rst_n),
    .in_s  (wh_link),
    .out_s (act_link)
  );

  aggr_stage u_aggr (
    .clk   (clk),
    .rst_n (rst_n),
    .in_s  (act_link),
    .out_s (out_link)
  );

  debug_monitor u_dbg (
    .clk          (clk),
    .rst_n        (rst_n),
    .clear_i      (dbg_clear_i),
    .watch_node_i (watch_node_i),
    .in_m         (in_link),
    .wh_m         (wh_link),
    .act_m        (act_link),
    .out_m        (out_link),
    .flags_o      (dbg_flags_o),
    .edges_o      (dbg_edges_o),
    .capture_o    (dbg_capture_o)
  );

endmodule

// ==== rtl/debug_monitor.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module debug_monitor import gat_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    clear_i,
  input  logic [`GAT_NODE_W-1:0]  watch_node_i,
  stream_if.mon                   in_m,
  stream_if.mon                   wh_m,
  stream_if.mon                   act_m,
  stream_if.mon                   out_m,
  output logic [7:0]              flags_o,
  output logic [31:0]             edges_o,
  output logic [`GAT_VALUE_W-1:0] capture_o
);

  localparam int NUM_LINKS = int'(LINK_OUT) + 1;

  logic [NUM_LINKS-1:0]    vld_bus;
  logic [NUM_LINKS-1:0]    rdy_bus;
  logic [2*NUM_LINKS-1:0]  flags_d;
  logic [2*NUM_LINKS-1:0]  flags_q;
  logic [31:0]             edges_q;
  logic [`GAT_VALUE_W-1:0] capture_q;
  logic                    edge_fire;
  logic                    watch_hit;

  assign vld_bus[LINK_IN]  = in_m.valid;
  assign vld_bus[LINK_WH]  = wh_m.valid;
  assign vld_bus[LINK_ACT] = act_m.valid;
  assign vld_bus[LINK_OUT] = out_m.valid;
  assign rdy_bus[LINK_IN]  = in_m.ready;
  assign rdy_bus[LINK_WH]  = wh_m.ready;
  assign rdy_bus[LINK_ACT] = act_m.ready;
  assign rdy_bus[LINK_OUT] = out_m.ready;

  // odd bit is valid seen, even bit is ready seen.
  always_comb begin
    for (int l = 0; l < NUM_LINKS; l++) begin
      flags_d[2*l+1] = flags_q[2*l+1] | vld_bus[l];
      flags_d[2*l]   = flags_q[2*l]   | rdy_bus[l];
    end
  end

  assign edge_fire = in_m.valid && in_m.ready;
  assign watch_hit = act_m.valid && act_m.ready && (act_m.node == watch_node_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q   <= '0;
      edges_q   <= '0;
      capture_q <= '0;
    end else if (clear_i) begin
      flags_q   <= '0;
      edges_q   <= '0;
      capture_q <= '0;
    end else begin
      flags_q <= flags_d;
      if (edge_fire) begin
        edges_q <= edges_q + 32'd1;
      end
      if (watch_hit) begin
        capture_q <= act_m.value;
      end
    end
  end

  assign flags_o   = flags_q;
  assign edges_o   = edges_q;
  assign capture_o = capture_q;

endmodule

// ==== rtl/aggr_stage.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module aggr_stage import gat_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  stream_if.dst in_s,
  stream_if.src out_s
);

  aggr_state_e             state_q;
  logic [`GAT_VALUE_W-1:0] acc_q;
  logic [`GAT_VALUE_W-1:0] acc_sum;
  logic [`GAT_VALUE_W-1:0] sum_q;
  logic [`GAT_NODE_W-1:0]  node_q;
  logic                    in_fire;
  logic                    out_fire;

  assign acc_sum  = acc_q + in_s.value;
  assign in_fire  = in_s.valid && in_s.ready;
  assign out_fire = out_s.valid && out_s.ready;

  // a held total blocks new edges until it leaves.
  assign in_s.ready = (state_q == ACC_COLLECT) || out_s.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ACC_COLLECT;
      acc_q   <= '0;
    end else if (in_fire) begin
      if (in_s.last) begin
        acc_q   <= '0;
        state_q <= ACC_HOLD;
      end else begin
        acc_q <= acc_sum;
        if (out_fire) begin
          state_q <= ACC_COLLECT;
        end
      end
    end else if (out_fire) begin
      state_q <= ACC_COLLECT;
    end
  end

  // output total and node of the finished edge list.
  always_ff @(posedge clk) begin
    if (in_fire && in_s.last) begin
      sum_q  <= acc_sum;
      node_q <= in_s.node;
    end
  end

  assign out_s.valid = (state_q == ACC_HOLD);
  assign out_s.node  = node_q;
  assign out_s.last  = 1'b1;
  assign out_s.value = sum_q;

endmodule

// ==== rtl/act_stage.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module act_stage (
  input  logic  clk,
  input  logic  rst_n,
  stream_if.dst in_s,
  stream_if.src out_s
);

  localparam logic signed [`GAT_VALUE_W-1:0] ACT_MAX =
    (32'sd1 <<< (`GAT_ACT_W - 1)) - 32'sd1;
  localparam logic signed [`GAT_VALUE_W-1:0] ACT_MIN =
    -(32'sd1 <<< (`GAT_ACT_W - 1));

  logic signed [`GAT_VALUE_W-1:0] score;
  logic signed [`GAT_VALUE_W-1:0] leaked;
  logic signed [`GAT_VALUE_W-1:0] clamped;
  logic                           in_fire;

  logic                           valid_q;
  logic [`GAT_NODE_W-1:0]         node_q;
  logic                           last_q;
  logic [`GAT_VALUE_W-1:0]        data_q;

  assign score   = in_s.value;
  assign leaked  = score[`GAT_VALUE_W-1] ? (score >>> `GAT_LEAK_SHIFT) : score;
  assign in_fire = in_s.valid && in_s.ready;

  always_comb begin
    if (leaked > ACT_MAX) begin
      clamped = ACT_MAX;
    end else if (leaked < ACT_MIN) begin
      clamped = ACT_MIN;
    end else begin
      clamped = leaked;
    end
  end

  assign in_s.ready = !valid_q || out_s.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_fire) begin
      valid_q <= 1'b1;
    end else if (out_s.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      node_q <= in_s.node;
      last_q <= in_s.last;
      data_q <= clamped;
    end
  end

  assign out_s.valid = valid_q;
  assign out_s.node  = node_q;
  assign out_s.last  = last_q;
  assign out_s.value = data_q;

endmodule

// ==== rtl/wh_stage.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

module wh_stage import gat_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wgt_we_i,
  input  logic [1:0]                    wgt_idx_i,
  input  logic signed [`GAT_FEAT_W-1:0] wgt_data_i,
  stream_if.dst                         in_s,
  stream_if.src                         out_s
);

  feat_lane_t                     wgt_q [`GAT_LANES];
  feat_vec_t                      feat;
  logic signed [`GAT_VALUE_W-1:0] dot;
  logic                           in_fire;

  logic                           valid_q;
  logic [`GAT_NODE_W-1:0]         node_q;
  logic                           last_q;
  logic [`GAT_VALUE_W-1:0]        data_q;

  assign feat    = in_s.value;
  assign in_fire = in_s.valid && in_s.ready;

  // weight register file.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `GAT_LANES; i++) begin
        wgt_q[i] <= '0;
      end
    end else if (wgt_we_i) begin
      wgt_q[wgt_idx_i] <= wgt_data_i;
    end
  end

  // products are widened to the full value width before summing.
  always_comb begin
    dot = '0;
    for (int i = 0; i < `GAT_LANES; i++) begin
      dot = dot + feat[i] * wgt_q[i];
    end
  end

  assign in_s.ready = !valid_q || out_s.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_fire) begin
      valid_q <= 1'b1;
    end else if (out_s.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      node_q <= in_s.node;
      last_q <= in_s.last;
      data_q <= dot;
    end
  end

  assign out_s.valid = valid_q;
  assign out_s.node  = node_q;
  assign out_s.last  = last_q;
  assign out_s.value = data_q;

endmodule

// ==== rtl/stream_if.sv ====
`timescale 1ns/10ps
`include "gat_macros.svh"

interface stream_if;

  logic                    valid;
  logic                    ready;
  logic [`GAT_NODE_W-1:0]  node;
  logic                    last;
  logic [`GAT_VALUE_W-1:0] value;

  modport src (
    output valid, node, last, value,
    input  ready
  );

  modport dst (
    input  valid, node, last, value,
    output ready
  );

  // observation only.
  modport mon (
    input valid, ready, node, last, value
  );

endinterface

// ==== rtl/gat_pkg.sv ====
`include "gat_macros.svh"

package gat_pkg;

  // one signed feature lane.
  typedef logic signed [`GAT_FEAT_W-1:0] feat_lane_t;

  // lane 0 sits in the low byte.
  typedef feat_lane_t [`GAT_LANES-1:0] feat_vec_t;

  // stream links watched by the debug monitor.
  typedef enum logic [1:0] {
    LINK_IN  = 2'd0,
    LINK_WH  = 2'd1,
    LINK_ACT = 2'd2,
    LINK_OUT = 2'd3
  } link_e;

  // aggregation control.
  typedef enum logic {
    ACC_COLLECT = 1'b0,
    ACC_HOLD    = 1'b1
  } aggr_state_e;

endpackage

// ==== rtl/gat_macros.svh ====
`ifndef GAT_MACROS_SVH
`define GAT_MACROS_SVH

// feature lanes per edge and the lane width shared with the weights.
`define GAT_LANES      4
`define GAT_FEAT_W     8

// stream payload and node id widths.
`define GAT_VALUE_W    32
`define GAT_NODE_W     8

// negative scores are divided by 2**GAT_LEAK_SHIFT.
`define GAT_LEAK_SHIFT 3
`define GAT_ACT_W      16

`endif
